/* all.f */
+incdir+src
src/dma_pkg.sv
src/dma_cmd_decode.sv
src/dma_channel_exec.sv
src/dma_sink_result.sv
src/dma_top.sv
testbench/dma_properties.sv
testbench/tb_dma.sv

/* run.sh */
#!/bin/sh
# Build and run the DMA channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dma +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1

/* src/dma_channel_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_channel_exec (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   i_enable,
  input  wire  dma_pkg::ip_t    i_start_ip,

  input  wire  dma_pkg::addr_t  i_src_addr,
  input  wire  dma_pkg::count_t i_count,
  input  wire  dma_pkg::ip_t    i_next,
  input  wire                   i_src_inc,
  input  wire                   i_src_dec,
  input  wire                   i_continue,

  input  wire                   i_room,
  input  wire                   i_src_ready,
  input  wire  dma_pkg::size_t  i_src_size,

  output dma_pkg::ip_t          o_ip,
  output logic                  o_src_activate,
  output logic                  o_src_strobe,
  output dma_pkg::addr_t        o_src_addr,
  output logic                  o_take,
  output logic                  o_load_dst,
  output logic                  o_release,
  output logic                  o_busy,
  output logic                  o_finished
);
  import dma_pkg::*;

  chan_state_t state;
  ip_t         ip;
  logic        first_cmd;

  logic        src_activate;
  logic        src_strobe;
  size_t       src_count;
  addr_t       src_addr;

  count_t      cmd_count;
  count_t      word_cnt;

  logic        take;
  logic        load_dst;
  logic        rel_pulse;

  logic        words_left;
  logic        can_xfer;

  assign words_left = (word_cnt < cmd_count);

  // Source open, sink has room, block not used up, command not done
  assign can_xfer = src_activate && i_room && (src_count < i_src_size) && words_left;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      ip           <= '0;
      first_cmd    <= 1'b0;
      src_activate <= 1'b0;
      src_strobe   <= 1'b0;
      src_count    <= '0;
      cmd_count    <= '0;
      word_cnt     <= '0;
      take         <= 1'b0;
      load_dst     <= 1'b0;
      rel_pulse    <= 1'b0;
    end else begin
      src_strobe <= 1'b0;
      take       <= 1'b0;
      load_dst   <= 1'b0;
      rel_pulse  <= 1'b0;

      case (state)
        IDLE: begin
          if (i_enable) begin
            ip        <= i_start_ip;
            first_cmd <= 1'b1;
            state     <= SETUP_COMMAND;
          end
        end

        SETUP_COMMAND: begin
          cmd_count <= i_count;
          word_cnt  <= '0;
          // Addresses come from the table only on the first command
          if (first_cmd) begin
            src_addr <= i_src_addr;
            load_dst <= 1'b1;
          end
          first_cmd <= 1'b0;
          state     <= ACTIVE;
        end

        ACTIVE: begin
          if (!i_enable) begin
            rel_pulse <= 1'b1;
            state     <= FLUSH;
          end else begin
            if (!src_activate && i_src_ready && words_left) begin
              src_activate <= 1'b1;
              src_count    <= '0;
            end else if (src_activate && (src_count >= i_src_size)) begin
              src_activate <= 1'b0;
            end

            if (can_xfer) begin
              src_strobe <= 1'b1;
              take       <= 1'b1;
              src_count  <= src_count + 1'b1;
              word_cnt   <= word_cnt + 1'b1;
              if (i_src_inc) begin
                src_addr <= src_addr + 1'b1;
              end else if (i_src_dec) begin
                src_addr <= src_addr - 1'b1;
              end
            end

            // Last word must have reached the sink register
            if (!words_left && !take) begin
              if (i_continue) begin
                ip    <= i_next;
                state <= SETUP_COMMAND;
              end else begin
                rel_pulse <= 1'b1;
                state     <= FLUSH;
              end
            end
          end
        end

        FLUSH: begin
          // Drain the open source block, words are dropped
          if (src_activate) begin
            if (src_count < i_src_size) begin
              src_strobe <= 1'b1;
              src_count  <= src_count + 1'b1;
            end else begin
              src_activate <= 1'b0;
            end
          end else begin
            state <= FINISHED;
          end
        end

        FINISHED: begin
          if (!i_enable) begin
            state <= IDLE;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign o_ip           = ip;
  assign o_src_activate = src_activate;
  assign o_src_strobe   = src_strobe;
  assign o_src_addr     = src_addr;
  assign o_take         = take;
  assign o_load_dst     = load_dst;
  assign o_release      = rel_pulse;
  assign o_busy         = (state != IDLE);
  assign o_finished     = (state == FINISHED);

endmodule

`default_nettype wire

/* src/dma_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_cmd_decode (
  input  wire                   clk,
  input  wire                   rst,

  input  wire                   i_cmd_wr,
  input  wire  dma_pkg::ip_t    i_cmd_index,
  input  wire  dma_pkg::addr_t  i_cmd_src_addr,
  input  wire  dma_pkg::addr_t  i_cmd_dst_addr,
  input  wire  dma_pkg::count_t i_cmd_count,
  input  wire  dma_pkg::flags_t i_cmd_flags,
  input  wire  dma_pkg::ip_t    i_cmd_next,

  input  wire  dma_pkg::ip_t    i_ip,

  output dma_pkg::addr_t        o_src_addr,
  output dma_pkg::addr_t        o_dst_addr,
  output dma_pkg::count_t       o_count,
  output dma_pkg::ip_t          o_next,
  output logic                  o_src_inc,
  output logic                  o_src_dec,
  output logic                  o_dst_inc,
  output logic                  o_dst_dec,
  output logic                  o_continue
);
  import dma_pkg::*;

  addr_t  src_mem   [`DMA_INST_COUNT];
  addr_t  dst_mem   [`DMA_INST_COUNT];
  count_t count_mem [`DMA_INST_COUNT];
  flags_t flags_mem [`DMA_INST_COUNT];
  ip_t    next_mem  [`DMA_INST_COUNT];

  // Valid bits of the table, only cleared by reset
  logic [`DMA_INST_COUNT-1:0] entry_valid;

  flags_t cur_flags;

  always_ff @(posedge clk) begin
    if (i_cmd_wr) begin
      src_mem[i_cmd_index]   <= i_cmd_src_addr;
      dst_mem[i_cmd_index]   <= i_cmd_dst_addr;
      count_mem[i_cmd_index] <= i_cmd_count;
      flags_mem[i_cmd_index] <= i_cmd_flags;
      next_mem[i_cmd_index]  <= i_cmd_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      entry_valid <= '0;
    end else if (i_cmd_wr) begin
      entry_valid[i_cmd_index] <= 1'b1;
    end
  end

  // An unwritten entry reads as an empty command that does not chain
  assign cur_flags  = entry_valid[i_ip] ? flags_mem[i_ip] : '0;
  assign o_count    = entry_valid[i_ip] ? count_mem[i_ip] : '0;
  assign o_src_addr = src_mem[i_ip];
  assign o_dst_addr = dst_mem[i_ip];
  assign o_next     = next_mem[i_ip];

  // Increment wins over decrement
  assign o_src_inc  = cur_flags[`DMA_FLAG_SRC_INC];
  assign o_src_dec  = cur_flags[`DMA_FLAG_SRC_DEC] & ~cur_flags[`DMA_FLAG_SRC_INC];
  assign o_dst_inc  = cur_flags[`DMA_FLAG_DST_INC];
  assign o_dst_dec  = cur_flags[`DMA_FLAG_DST_DEC] & ~cur_flags[`DMA_FLAG_DST_INC];
  assign o_continue = cur_flags[`DMA_FLAG_CONTINUE];

endmodule

`default_nettype wire

/* src/dma_defines.svh */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Bus widths
`define DMA_ADDR_W          64
`define DMA_DATA_W          32
`define DMA_SIZE_W          24
`define DMA_CNT_W           32

// Command table
`define DMA_INST_COUNT      8
`define DMA_IP_W            3
`define DMA_FLAG_W          16

// Flag bit positions within a command entry
`define DMA_FLAG_SRC_INC    0
`define DMA_FLAG_SRC_DEC    1
`define DMA_FLAG_DST_INC    2
`define DMA_FLAG_DST_DEC    3
`define DMA_FLAG_CONTINUE   4

`endif

/* src/dma_pkg.sv */
`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;

  // FIFO block sizes and the counts against them
  typedef logic [`DMA_SIZE_W-1:0] size_t;

  // Words per command
  typedef logic [`DMA_CNT_W-1:0]  count_t;

  typedef logic [`DMA_IP_W-1:0]   ip_t;
  typedef logic [`DMA_FLAG_W-1:0] flags_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP_COMMAND,
    ACTIVE,
    FLUSH,
    FINISHED
  } chan_state_t;

endpackage

`default_nettype wire

/* src/dma_sink_result.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_sink_result (
  input  wire                  clk,
  input  wire                  rst,

  input  wire                  i_take,
  input  wire                  i_load_dst,
  input  wire                  i_release,

  input  wire  dma_pkg::addr_t i_dst_addr,
  input  wire                  i_dst_inc,
  input  wire                  i_dst_dec,
  input  wire  dma_pkg::data_t i_src_data,

  input  wire  [1:0]           i_snk_ready,
  input  wire  dma_pkg::size_t i_snk_size,

  output logic                 o_room,
  output logic [1:0]           o_snk_activate,
  output logic                 o_snk_strobe,
  output dma_pkg::data_t       o_snk_data,
  output dma_pkg::addr_t       o_snk_addr
);
  import dma_pkg::*;

  logic [1:0] snk_act;
  size_t      blk_cnt;
  size_t      blk_next;
  logic       snk_strobe;
  data_t      snk_data;
  addr_t      dst_addr;
  logic       blk_full;

  // Count includes the word currently being taken
  assign blk_next = blk_cnt + size_t'(i_take);
  assign blk_full = (snk_act != 2'b00) && (blk_cnt >= i_snk_size);
  assign o_room   = (snk_act != 2'b00) && (blk_next < i_snk_size);

  // Half selection, lowest ready half first
  always_ff @(posedge clk) begin
    if (rst) begin
      snk_act <= 2'b00;
      blk_cnt <= '0;
    end else if (i_release || blk_full) begin
      snk_act <= 2'b00;
    end else if (snk_act == 2'b00) begin
      if (i_snk_ready[0]) begin
        snk_act <= 2'b01;
        blk_cnt <= '0;
      end else if (i_snk_ready[1]) begin
        snk_act <= 2'b10;
        blk_cnt <= '0;
      end
    end else begin
      blk_cnt <= blk_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      snk_strobe <= 1'b0;
    end else begin
      snk_strobe <= i_take;
    end
  end

  always_ff @(posedge clk) begin
    if (i_take) begin
      snk_data <= i_src_data;
    end
  end

  // Address of the next word to land in the sink
  always_ff @(posedge clk) begin
    if (i_load_dst) begin
      dst_addr <= i_dst_addr;
    end else if (snk_strobe) begin
      if (i_dst_inc) begin
        dst_addr <= dst_addr + 1'b1;
      end else if (i_dst_dec) begin
        dst_addr <= dst_addr - 1'b1;
      end
    end
  end

  assign o_snk_activate = snk_act;
  assign o_snk_strobe   = snk_strobe;
  assign o_snk_data     = snk_data;
  assign o_snk_addr     = dst_addr;

endmodule

`default_nettype wire

/* src/dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_top (
  input  wire                   clk,
  input  wire                   rst,

  input  wire                   i_cmd_wr,
  input  wire  dma_pkg::ip_t    i_cmd_index,
  input  wire  dma_pkg::addr_t  i_cmd_src_addr,
  input  wire  dma_pkg::addr_t  i_cmd_dst_addr,
  input  wire  dma_pkg::count_t i_cmd_count,
  input  wire  dma_pkg::flags_t i_cmd_flags,
  input  wire  dma_pkg::ip_t    i_cmd_next,

  input  wire                   i_enable,
  input  wire  dma_pkg::ip_t    i_start_ip,

  input  wire  dma_pkg::data_t  i_src_data,
  input  wire                   i_src_ready,
  input  wire  dma_pkg::size_t  i_src_size,
  output logic                  o_src_activate,
  output logic                  o_src_strobe,
  output dma_pkg::addr_t        o_src_addr,

  input  wire  [1:0]            i_snk_ready,
  input  wire  dma_pkg::size_t  i_snk_size,
  output logic [1:0]            o_snk_activate,
  output logic                  o_snk_strobe,
  output dma_pkg::data_t        o_snk_data,
  output dma_pkg::addr_t        o_snk_addr,

  output logic                  o_busy,
  output logic                  o_finished
);
  import dma_pkg::*;

  // Current entry fields
  ip_t    cur_ip;
  addr_t  cur_src_addr;
  addr_t  cur_dst_addr;
  count_t cur_count;
  ip_t    cur_next;
  logic   cur_src_inc;
  logic   cur_src_dec;
  logic   cur_dst_inc;
  logic   cur_dst_dec;
  logic   cur_continue;

  logic   take;
  logic   load_dst;
  logic   release_blk;
  logic   room;

  dma_cmd_decode decode_i (
    .clk            (clk),
    .rst            (rst),
    .i_cmd_wr       (i_cmd_wr),
    .i_cmd_index    (i_cmd_index),
    .i_cmd_src_addr (i_cmd_src_addr),
    .i_cmd_dst_addr (i_cmd_dst_addr),
    .i_cmd_count    (i_cmd_count),
    .i_cmd_flags    (i_cmd_flags),
    .i_cmd_next     (i_cmd_next),
    .i_ip           (cur_ip),
    .o_src_addr     (cur_src_addr),
    .o_dst_addr     (cur_dst_addr),
    .o_count        (cur_count),
    .o_next         (cur_next),
    .o_src_inc      (cur_src_inc),
    .o_src_dec      (cur_src_dec),
    .o_dst_inc      (cur_dst_inc),
    .o_dst_dec      (cur_dst_dec),
    .o_continue     (cur_continue)
  );

  dma_channel_exec exec_i (
    .clk            (clk),
    .rst            (rst),
    .i_enable       (i_enable),
    .i_start_ip     (i_start_ip),
    .i_src_addr     (cur_src_addr),
    .i_count        (cur_count),
    .i_next         (cur_next),
    .i_src_inc      (cur_src_inc),
    .i_src_dec      (cur_src_dec),
    .i_continue     (cur_continue),
    .i_room         (room),
    .i_src_ready    (i_src_ready),
    .i_src_size     (i_src_size),
    .o_ip           (cur_ip),
    .o_src_activate (o_src_activate),
    .o_src_strobe   (o_src_strobe),
    .o_src_addr     (o_src_addr),
    .o_take         (take),
    .o_load_dst     (load_dst),
    .o_release      (release_blk),
    .o_busy         (o_busy),
    .o_finished     (o_finished)
  );

  dma_sink_result result_i (
    .clk            (clk),
    .rst            (rst),
    .i_take         (take),
    .i_load_dst     (load_dst),
    .i_release      (release_blk),
    .i_dst_addr     (cur_dst_addr),
    .i_dst_inc      (cur_dst_inc),
    .i_dst_dec      (cur_dst_dec),
    .i_src_data     (i_src_data),
    .i_snk_ready    (i_snk_ready),
    .i_snk_size     (i_snk_size),
    .o_room         (room),
    .o_snk_activate (o_snk_activate),
    .o_snk_strobe   (o_snk_strobe),
    .o_snk_data     (o_snk_data),
    .o_snk_addr     (o_snk_addr)
  );

endmodule

`default_nettype wire

/* testbench/dma_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_properties (
  input wire       clk,
  input wire       rst,
  input wire       i_src_strobe,
  input wire       i_src_activate,
  input wire [1:0] i_snk_activate,
  input wire       i_snk_strobe,
  input wire       i_busy,
  input wire       i_finished,
  input wire       i_active
);

  // Failure tally, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  a_src_strobe_active: assert property (@(posedge clk) disable iff (rst)
    i_src_strobe |-> i_src_activate)
    else begin
      $error("source strobe while the source block is not active");
      fail_cnt++;
    end

  a_snk_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(i_snk_activate))
    else begin
      $error("more than one sink half active");
      fail_cnt++;
    end

  a_snk_strobe_active: assert property (@(posedge clk) disable iff (rst)
    i_snk_strobe |-> (i_snk_activate != 2'b00))
    else begin
      $error("sink strobe with no sink half active");
      fail_cnt++;
    end

  // Word strobed while the channel is ACTIVE lands in the sink one cycle later
  a_word_latency: assert property (@(posedge clk) disable iff (rst)
    (i_src_strobe && i_active) |=> i_snk_strobe)
    else begin
      $error("source strobe not followed by a sink strobe");
      fail_cnt++;
    end

  a_reset_state: assert property (@(posedge clk)
    rst |=> (!i_busy && !i_finished && !i_src_activate && !i_src_strobe &&
             (i_snk_activate == 2'b00) && !i_snk_strobe))
    else begin
      $error("control outputs not low after reset");
      fail_cnt++;
    end

endmodule

bind dma_top dma_properties props_i (
  .clk            (clk),
  .rst            (rst),
  .i_src_strobe   (o_src_strobe),
  .i_src_activate (o_src_activate),
  .i_snk_activate (o_snk_activate),
  .i_snk_strobe   (o_snk_strobe),
  .i_busy         (o_busy),
  .i_finished     (o_finished),
  .i_active       (exec_i.state == dma_pkg::ACTIVE)
);

`default_nettype wire

/* testbench/tb_dma.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module tb_dma;
  import dma_pkg::*;

  // Longest test is the back-pressured one, a few hundred cycles
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int SRC_BLOCK      = 4;
  localparam int SNK_BLOCK      = 3;

  localparam flags_t F_SRC_INC  = flags_t'(1 << `DMA_FLAG_SRC_INC);
  localparam flags_t F_SRC_DEC  = flags_t'(1 << `DMA_FLAG_SRC_DEC);
  localparam flags_t F_DST_INC  = flags_t'(1 << `DMA_FLAG_DST_INC);
  localparam flags_t F_DST_DEC  = flags_t'(1 << `DMA_FLAG_DST_DEC);
  localparam flags_t F_CONTINUE = flags_t'(1 << `DMA_FLAG_CONTINUE);

  logic       clk = 1'b0;
  logic       rst;
  logic       i_cmd_wr;
  ip_t        i_cmd_index;
  addr_t      i_cmd_src_addr;
  addr_t      i_cmd_dst_addr;
  count_t     i_cmd_count;
  flags_t     i_cmd_flags;
  ip_t        i_cmd_next;
  logic       i_enable;
  ip_t        i_start_ip;
  data_t      i_src_data;
  logic       i_src_ready;
  size_t      i_src_size;
  logic [1:0] i_snk_ready;
  size_t      i_snk_size;
  logic       o_src_activate;
  logic       o_src_strobe;
  addr_t      o_src_addr;
  logic [1:0] o_snk_activate;
  logic       o_snk_strobe;
  data_t      o_snk_data;
  addr_t      o_snk_addr;
  logic       o_busy;
  logic       o_finished;

  // Models and scoreboard
  logic [31:0] rng = 32'hedaa;
  data_t       src_word;
  logic        src_strobe_q = 1'b0;
  logic        bp_mode = 1'b0;
  data_t       exp_data[$];
  int          exp_step[$];
  addr_t       exp_addr;
  addr_t       exp_src_addr;
  int unsigned total = 0;
  int unsigned kept_cnt = 0;
  int unsigned rx_cnt = 0;
  int unsigned run_strobes = 0;
  int unsigned first_cnt = 0;
  flags_t      first_flags;
  flags_t      second_flags;
  logic        saw_finished;
  int unsigned err_cnt = 0;
  int unsigned cycles = 0;

  dma_top dut_i (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Address step after word n, from the flags of the entry it belongs to
  function automatic int addr_step(input int unsigned n, input int inc_pos,
                                   input int dec_pos);
    flags_t f;
    f = (n < first_cnt) ? first_flags : second_flags;
    if (f[inc_pos]) begin
      return 1;
    end else if (f[dec_pos]) begin
      return -1;
    end
    return 0;
  endfunction

  // One clock cycle; inputs change 1 ns after the rising edge
  task automatic step();
    logic  en_edge;
    data_t d;
    int    s;
    int    sstep;
    en_edge = i_enable;
    @(posedge clk);
    #1;
    if (src_strobe_q) begin
      src_word = xorshift(src_word);
    end
    i_src_data   = src_word;
    src_strobe_q = o_src_strobe;
    if (o_src_strobe) begin
      run_strobes++;
      if (en_edge && kept_cnt < total) begin
        exp_data.push_back(src_word);
        exp_step.push_back(addr_step(kept_cnt, `DMA_FLAG_DST_INC, `DMA_FLAG_DST_DEC));
        // Source address has already moved past the word being strobed
        sstep = addr_step(kept_cnt, `DMA_FLAG_SRC_INC, `DMA_FLAG_SRC_DEC);
        if (sstep > 0) begin
          exp_src_addr = exp_src_addr + 64'd1;
        end else if (sstep < 0) begin
          exp_src_addr = exp_src_addr - 64'd1;
        end
        if (o_src_addr !== exp_src_addr) begin
          $display("error at %0t ns: o_src_addr expected %h got %h",
                   $time, exp_src_addr, o_src_addr);
          err_cnt++;
        end
        kept_cnt++;
      end
    end
    if (o_snk_strobe) begin
      rx_cnt++;
      if (exp_data.size() == 0) begin
        $display("error at %0t ns: sink strobe with no source word pending", $time);
        err_cnt++;
      end else begin
        d = exp_data.pop_front();
        s = exp_step.pop_front();
        if (o_snk_data !== d) begin
          $display("error at %0t ns: o_snk_data expected %h got %h", $time, d, o_snk_data);
          err_cnt++;
        end
        if (o_snk_addr !== exp_addr) begin
          $display("error at %0t ns: o_snk_addr expected %h got %h",
                   $time, exp_addr, o_snk_addr);
          err_cnt++;
        end
        if (s > 0) begin
          exp_addr = exp_addr + 64'd1;
        end else if (s < 0) begin
          exp_addr = exp_addr - 64'd1;
        end
      end
    end
    if (o_finished) begin
      saw_finished = 1'b1;
    end
    rng = xorshift(rng);
    i_src_ready = rng[0];
    if (bp_mode) begin
      // Sink mostly stalled
      i_snk_ready = (rng[9:4] == 6'd0) ? rng[2:1] : 2'b00;
    end else begin
      i_snk_ready = rng[2:1];
    end
  endtask

  task automatic write_entry(input ip_t idx, input addr_t src, input addr_t dst,
                             input count_t cnt, input flags_t flags, input ip_t nxt);
    i_cmd_index    = idx;
    i_cmd_src_addr = src;
    i_cmd_dst_addr = dst;
    i_cmd_count    = cnt;
    i_cmd_flags    = flags;
    i_cmd_next     = nxt;
    i_cmd_wr       = 1'b1;
    step();
    i_cmd_wr = 1'b0;
  endtask

  // Runs from start_ip; stop_after > 0 drops enable once that many words arrived
  task automatic run_channel(input ip_t start_ip, input addr_t src0, input addr_t dst0,
                             input int unsigned cnt0, input flags_t fl0,
                             input int unsigned cnt1, input flags_t fl1,
                             input int unsigned stop_after);
    first_cnt    = cnt0;
    first_flags  = fl0;
    second_flags = fl1;
    total        = cnt0 + cnt1;
    exp_addr     = dst0;
    exp_src_addr = src0;
    kept_cnt     = 0;
    rx_cnt       = 0;
    run_strobes  = 0;
    saw_finished = 1'b0;
    i_start_ip   = start_ip;
    i_enable     = 1'b1;
    step();
    if (stop_after > 0) begin
      while (rx_cnt < stop_after || !o_src_activate) begin
        step();
      end
    end else begin
      while (!o_finished) begin
        step();
      end
    end
    i_enable = 1'b0;
    while (o_busy) begin
      step();
    end
    step();
    if (o_busy || o_finished) begin
      $display("error at %0t ns: channel did not return to idle", $time);
      err_cnt++;
    end
    if (!saw_finished) begin
      $display("error at %0t ns: o_finished never went high", $time);
      err_cnt++;
    end
    if (exp_data.size() != 0) begin
      $display("error at %0t ns: %0d words never reached the sink", $time, exp_data.size());
      err_cnt++;
      exp_data.delete();
      exp_step.delete();
    end
    if (stop_after == 0 && kept_cnt != total) begin
      $display("error at %0t ns: words moved expected %0d got %0d", $time, total, kept_cnt);
      err_cnt++;
    end
    if (stop_after > 0 && kept_cnt >= total) begin
      $display("error at %0t ns: disable did not cut the transfer short", $time);
      err_cnt++;
    end
    // Every source block is drained to its full size
    if (run_strobes % SRC_BLOCK != 0 || o_src_activate) begin
      $display("error at %0t ns: source block left partly drained (%0d strobes)",
               $time, run_strobes);
      err_cnt++;
    end
    total = 0;
  endtask

  initial begin
    rst            = 1'b1;
    i_cmd_wr       = 1'b0;
    i_cmd_index    = '0;
    i_cmd_src_addr = '0;
    i_cmd_dst_addr = '0;
    i_cmd_count    = '0;
    i_cmd_flags    = '0;
    i_cmd_next     = '0;
    i_enable       = 1'b0;
    i_start_ip     = '0;
    src_word       = xorshift(32'hedaa);
    i_src_data     = src_word;
    i_src_ready    = 1'b0;
    i_src_size     = size_t'(SRC_BLOCK);
    i_snk_ready    = 2'b00;
    i_snk_size     = size_t'(SNK_BLOCK);
    #1;
    step();
    step();
    rst = 1'b0;

    if (o_busy || o_finished || o_src_activate || o_src_strobe ||
        o_snk_activate != 2'b00 || o_snk_strobe) begin
      $display("error at %0t ns: control outputs not low after reset", $time);
      err_cnt++;
    end

    write_entry(3'd2, 64'h1000, 64'h8000, 32'd10, F_SRC_INC | F_DST_INC, 3'd0);
    run_channel(3'd2, 64'h1000, 64'h8000, 10, F_SRC_INC | F_DST_INC, 0, '0, 0);

    // Chain 0 -> 5, second source and destination bases are not used
    write_entry(3'd0, 64'h2000, 64'h0200, 32'd6, F_SRC_INC | F_DST_INC | F_CONTINUE, 3'd5);
    write_entry(3'd5, 64'h3000, 64'h9999, 32'd7, F_SRC_INC | F_DST_DEC, 3'd0);
    run_channel(3'd0, 64'h2000, 64'h0200, 6, F_SRC_INC | F_DST_INC,
                7, F_SRC_INC | F_DST_DEC, 0);

    bp_mode = 1'b1;
    write_entry(3'd3, 64'h4000, 64'h0400, 32'd12, F_SRC_DEC | F_DST_INC, 3'd0);
    run_channel(3'd3, 64'h4000, 64'h0400, 12, F_SRC_DEC | F_DST_INC, 0, '0, 0);
    bp_mode = 1'b0;

    write_entry(3'd7, 64'h5000, 64'h0700, 32'd20, F_SRC_INC | F_DST_INC, 3'd0);
    run_channel(3'd7, 64'h5000, 64'h0700, 20, F_SRC_INC | F_DST_INC, 0, '0, 5);

    $display("errors: %0d scoreboard, %0d assertion", err_cnt, dut_i.props_i.fail_cnt);
    if (err_cnt == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
